// File: logic/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address width in bits
`define FETCH_XLEN 32
// fetch blocks never cross this alignment
`define FETCH_BLOCK_BYTES 8
// instructions handed to the backend per cycle
`define FETCH_SLOTS 4
// fetch target queue entries, power of two
`define FTQ_DEPTH 8
`define FETCH_RESET_PC 32'h0000_1000
// direct mapped, indexed by block address bits
`define BTB_ENTRIES 4
// two 8-byte words per memory read
`define MEM_DATA_BITS 128

`endif

// File: logic/fetch_addr_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_addr_pkg;

    // one fetch block, runs to the next 8-byte boundary
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] start_addr;
        // 1 to 8 bytes
        logic [3:0]             block_len;
    } fetch_block_t;

    // taken-branch target entry
    typedef struct packed {
        logic                   vld;
        // full block address, start_addr[31:3]
        logic [`FETCH_XLEN-4:0] tag;
        logic [`FETCH_XLEN-1:0] target;
    } btb_entry_t;

    typedef enum logic {
        IDLE,
        RUN
    } pred_state_e;

endpackage

`default_nettype wire

// File: logic/fetch_inst_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_inst_pkg;

    typedef enum logic {
        INST16,
        INST32
    } inst_kind_e;

    typedef enum logic {
        FAULT_NONE,
        FAULT_MISALIGNED
    } fetch_fault_e;

    // upper half of inst is zero for compressed instructions
    typedef struct packed {
        logic [31:0]            inst;
        logic [`FETCH_XLEN-1:0] pc;
        inst_kind_e             kind;
        fetch_fault_e           fault;
    } fetch_slot_t;

endpackage

`default_nettype wire

// File: logic/block_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

// fetch block handshake, transfer when vld and rdy are both high
interface block_if;

    logic                   vld;
    logic                   rdy;
    logic [`FETCH_XLEN-1:0] start_addr;
    logic [3:0]             block_len;

    // producer holds the block fields until the transfer
    modport src (output vld, output start_addr, output block_len, input rdy);

    modport dst (input vld, input start_addr, input block_len, output rdy);

endinterface

`default_nettype wire

// File: logic/next_block_pred.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module next_block_pred (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   i_squash_vld,
    input  logic [`FETCH_XLEN-1:0] i_squash_pc,

    input  logic                   i_br_update_vld,
    input  logic [`FETCH_XLEN-1:0] i_br_update_pc,
    input  logic [`FETCH_XLEN-1:0] i_br_update_target,

    block_if.src                   o_blk
);

    fetch_addr_pkg::pred_state_e  state;
    logic [`FETCH_XLEN-1:0]       cur_pc;
    fetch_addr_pkg::fetch_block_t cur_blk;
    fetch_addr_pkg::btb_entry_t   btb [`BTB_ENTRIES];

    logic [$clog2(`BTB_ENTRIES)-1:0] pred_idx;
    logic [$clog2(`BTB_ENTRIES)-1:0] upd_idx;
    logic                            btb_hit;
    logic [`FETCH_XLEN-1:0]          next_pc;
    logic                            xfer;

    // block length runs up to the next 8-byte boundary
    always_comb begin
        cur_blk.start_addr = cur_pc;
        cur_blk.block_len  = 4'(`FETCH_BLOCK_BYTES) - {1'b0, cur_pc[2:0]};
    end

    assign o_blk.vld        = (state == fetch_addr_pkg::RUN);
    assign o_blk.start_addr = cur_blk.start_addr;
    assign o_blk.block_len  = cur_blk.block_len;

    assign xfer = o_blk.vld && o_blk.rdy;

    // table lookup on the current block address
    assign pred_idx = cur_pc[3 +: $clog2(`BTB_ENTRIES)];
    assign btb_hit  = btb[pred_idx].vld && (btb[pred_idx].tag == cur_pc[`FETCH_XLEN-1:3]);

    always_comb begin
        if (btb_hit) begin
            next_pc = btb[pred_idx].target;
        end else begin
            // fall through to the next aligned block
            next_pc = {cur_pc[`FETCH_XLEN-1:3] + 1'b1, 3'b000};
        end
    end

    // first cycle after reset or squash offers nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= fetch_addr_pkg::IDLE;
            cur_pc <= `FETCH_RESET_PC;
        end else if (i_squash_vld) begin
            state  <= fetch_addr_pkg::IDLE;
            cur_pc <= i_squash_pc;
        end else begin
            state <= fetch_addr_pkg::RUN;
            if (xfer) begin
                cur_pc <= next_pc;
            end
        end
    end

    assign upd_idx = i_br_update_pc[3 +: $clog2(`BTB_ENTRIES)];

    // backend installs taken targets, squash leaves the table alone
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < `BTB_ENTRIES; e++) begin
                btb[e].vld <= 1'b0;
            end
        end else if (i_br_update_vld) begin
            btb[upd_idx].vld    <= 1'b1;
            btb[upd_idx].tag    <= i_br_update_pc[`FETCH_XLEN-1:3];
            btb[upd_idx].target <= i_br_update_target;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_target_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_target_queue (
    input  logic clk,
    input  logic rst,

    input  logic i_flush,

    block_if.dst i_blk,
    block_if.src o_blk
);

    fetch_addr_pkg::fetch_block_t mem [`FTQ_DEPTH];

    logic [$clog2(`FTQ_DEPTH)-1:0] rd_ptr;
    logic [$clog2(`FTQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(`FTQ_DEPTH):0]   count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    // depth is a power of two, so the top count bit means full
    assign full  = count[$clog2(`FTQ_DEPTH)];
    assign empty = (count == '0);

    // no push while full, even with a pop in the same cycle
    assign i_blk.rdy = !full;
    assign push      = i_blk.vld && i_blk.rdy;

    assign o_blk.vld        = !empty;
    assign o_blk.start_addr = mem[rd_ptr].start_addr;
    assign o_blk.block_len  = mem[rd_ptr].block_len;
    assign pop              = o_blk.vld && o_blk.rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr].start_addr <= i_blk.start_addr;
            mem[wr_ptr].block_len  <= i_blk.block_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_aligner (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          i_flush,
    input  logic                          i_fetch_rdy,

    block_if.dst                          i_blk,

    output logic                          o_mem_req,
    output logic [`FETCH_XLEN-1:0]        o_mem_addr,
    input  logic [`MEM_DATA_BITS-1:0]     i_mem_rdata,

    output logic [`FETCH_SLOTS-1:0]       o_fetch_vld,
    output fetch_inst_pkg::fetch_slot_t   o_fetch_slot [`FETCH_SLOTS]
);

    logic                         take;
    logic                         s1_vld;
    fetch_addr_pkg::fetch_block_t s1_blk;

    logic [`MEM_DATA_BITS-1:0]    line;
    logic [`FETCH_SLOTS-1:0]      in_blk;
    logic [`FETCH_SLOTS-1:0]      hw_start;
    logic [`FETCH_SLOTS-1:0]      is32;
    logic [`FETCH_SLOTS-1:0]      hw_inst;

    logic [`FETCH_SLOTS-1:0]      lane_vld;
    fetch_inst_pkg::fetch_slot_t  lane_slot [`FETCH_SLOTS];

    // a block is taken only while the backend accepts
    assign i_blk.rdy  = i_fetch_rdy;
    assign take       = i_blk.vld && i_fetch_rdy;
    assign o_mem_req  = take;
    assign o_mem_addr = {i_blk.start_addr[`FETCH_XLEN-1:3], 3'b000};

    // stage 1 holds the block while memory reads
    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_blk.start_addr <= i_blk.start_addr;
            s1_blk.block_len  <= i_blk.block_len;
        end
    end

    // halfword 0 of line is the first halfword of the block
    assign line = i_mem_rdata >> {s1_blk.start_addr[2:1], 4'b0000};

    // 32-bit marker chain, a marked halfword swallows the next one
    always_comb begin
        logic prev32;
        prev32 = 1'b0;
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            in_blk[i]   = (4'(2 * i) < s1_blk.block_len);
            hw_start[i] = !prev32;
            is32[i]     = hw_start[i] && (line[16*i +: 2] == 2'b11);
            hw_inst[i]  = hw_start[i] && in_blk[i];
            prev32      = is32[i];
        end
    end

    // pack instructions into lanes from lane 0
    always_comb begin
        logic [$clog2(`FETCH_SLOTS)-1:0] n;
        n        = '0;
        lane_vld = '0;
        for (int l = 0; l < `FETCH_SLOTS; l++) begin
            lane_slot[l] = '0;
        end
        if (s1_blk.start_addr[0]) begin
            // odd pc gives a single fault slot
            lane_vld[0]        = 1'b1;
            lane_slot[0].pc    = s1_blk.start_addr;
            lane_slot[0].kind  = fetch_inst_pkg::INST16;
            lane_slot[0].fault = fetch_inst_pkg::FAULT_MISALIGNED;
        end else begin
            for (int i = 0; i < `FETCH_SLOTS; i++) begin
                if (hw_inst[i]) begin
                    lane_vld[n]        = 1'b1;
                    lane_slot[n].pc    = s1_blk.start_addr + `FETCH_XLEN'(2 * i);
                    lane_slot[n].fault = fetch_inst_pkg::FAULT_NONE;
                    if (is32[i]) begin
                        lane_slot[n].inst = line[16*i +: 32];
                        lane_slot[n].kind = fetch_inst_pkg::INST32;
                    end else begin
                        lane_slot[n].inst = {16'h0000, line[16*i +: 16]};
                        lane_slot[n].kind = fetch_inst_pkg::INST16;
                    end
                    n = n + 1'b1;
                end
            end
        end
    end

    // stage 2 output registers
    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            o_fetch_vld <= '0;
        end else begin
            o_fetch_vld <= s1_vld ? lane_vld : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            o_fetch_slot <= lane_slot;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        i_squash_vld,
    input  logic [`FETCH_XLEN-1:0]      i_squash_pc,

    input  logic                        i_br_update_vld,
    input  logic [`FETCH_XLEN-1:0]      i_br_update_pc,
    input  logic [`FETCH_XLEN-1:0]      i_br_update_target,

    output logic                        o_mem_req,
    output logic [`FETCH_XLEN-1:0]      o_mem_addr,
    input  logic [`MEM_DATA_BITS-1:0]   i_mem_rdata,

    input  logic                        i_fetch_rdy,
    output logic [`FETCH_SLOTS-1:0]     o_fetch_vld,
    output fetch_inst_pkg::fetch_slot_t o_fetch_slot [`FETCH_SLOTS]
);

    block_if pred_q ();
    block_if q_align ();

    next_block_pred u_pred (
        .clk                ( clk                ),
        .rst                ( rst                ),
        .i_squash_vld       ( i_squash_vld       ),
        .i_squash_pc        ( i_squash_pc        ),
        .i_br_update_vld    ( i_br_update_vld    ),
        .i_br_update_pc     ( i_br_update_pc     ),
        .i_br_update_target ( i_br_update_target ),
        .o_blk              ( pred_q             )
    );

    // squash flushes every stage on the same edge
    fetch_target_queue u_ftq (
        .clk     ( clk          ),
        .rst     ( rst          ),
        .i_flush ( i_squash_vld ),
        .i_blk   ( pred_q       ),
        .o_blk   ( q_align      )
    );

    fetch_aligner u_align (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .i_flush      ( i_squash_vld ),
        .i_fetch_rdy  ( i_fetch_rdy  ),
        .i_blk        ( q_align      ),
        .o_mem_req    ( o_mem_req    ),
        .o_mem_addr   ( o_mem_addr   ),
        .i_mem_rdata  ( i_mem_rdata  ),
        .o_fetch_vld  ( o_fetch_vld  ),
        .o_fetch_slot ( o_fetch_slot )
    );

endmodule

`default_nettype wire

// File: bench/fetch_ref.svh
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// reference model, reads mem_hw and the ref_btb arrays of the testbench

function automatic logic [15:0] read_hw(input logic [`FETCH_XLEN-1:0] addr);
    return mem_hw[addr[12:1]];
endfunction

// bytes up to the next 8-byte boundary
function automatic logic [3:0] block_len_of(input logic [`FETCH_XLEN-1:0] a);
    return 4'(`FETCH_BLOCK_BYTES - a[2:0]);
endfunction

function automatic logic table_hit(input logic [`FETCH_XLEN-1:0] a);
    logic [1:0] idx;
    idx = a[4:3];
    return ref_btb_vld[idx] && (ref_btb_tag[idx] == a[`FETCH_XLEN-1:3]);
endfunction

function automatic logic [`FETCH_XLEN-1:0] next_block(input logic [`FETCH_XLEN-1:0] a);
    if (table_hit(a)) begin
        return ref_btb_target[a[4:3]];
    end
    return {a[`FETCH_XLEN-1:3], 3'b000} + 32'd8;
endfunction

function automatic void expected_slots(
    input  logic [`FETCH_XLEN-1:0]                         a,
    output logic [`FETCH_SLOTS-1:0]                        vld,
    output fetch_inst_pkg::fetch_slot_t [`FETCH_SLOTS-1:0] slots
);
    int          off;
    int          n;
    logic [15:0] hw;
    vld   = '0;
    slots = '0;
    if (a[0]) begin
        // odd start gives a lone fault slot
        vld[0]         = 1'b1;
        slots[0].pc    = a;
        slots[0].fault = fetch_inst_pkg::FAULT_MISALIGNED;
        return;
    end
    off = 0;
    n   = 0;
    while (off < block_len_of(a)) begin
        hw             = read_hw(a + off);
        vld[n]         = 1'b1;
        slots[n].pc    = a + off;
        slots[n].fault = fetch_inst_pkg::FAULT_NONE;
        if (hw[1:0] == 2'b11) begin
            // upper half may sit in the following word
            slots[n].inst = {read_hw(a + off + 2), hw};
            slots[n].kind = fetch_inst_pkg::INST32;
            off           = off + 4;
        end else begin
            slots[n].inst = {16'h0000, hw};
            slots[n].kind = fetch_inst_pkg::INST16;
            off           = off + 2;
        end
        n = n + 1;
    end
endfunction

`endif

// File: bench/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_top;

    localparam int CYCLE_LIMIT = 4000;
    localparam int MEM_HWORDS  = 4096;

    logic                        clk;
    logic                        rst;
    logic                        i_squash_vld;
    logic [`FETCH_XLEN-1:0]      i_squash_pc;
    logic                        i_br_update_vld;
    logic [`FETCH_XLEN-1:0]      i_br_update_pc;
    logic [`FETCH_XLEN-1:0]      i_br_update_target;
    logic                        o_mem_req;
    logic [`FETCH_XLEN-1:0]      o_mem_addr;
    logic [`MEM_DATA_BITS-1:0]   i_mem_rdata;
    logic                        i_fetch_rdy;
    logic [`FETCH_SLOTS-1:0]     o_fetch_vld;
    fetch_inst_pkg::fetch_slot_t o_fetch_slot [`FETCH_SLOTS];

    // one halfword per entry over 0x0000 to 0x1fff
    logic [15:0]            mem_hw [MEM_HWORDS];
    logic                   ref_btb_vld    [`BTB_ENTRIES];
    logic [`FETCH_XLEN-4:0] ref_btb_tag    [`BTB_ENTRIES];
    logic [`FETCH_XLEN-1:0] ref_btb_target [`BTB_ENTRIES];
    logic [`FETCH_XLEN-1:0] ref_pc;
    logic                   hit_pending = 1'b0;
    logic                   req_seen = 1'b0;
    logic [`FETCH_XLEN-1:0] req_addr;

    int errors = 0;
    int blocks_checked = 0;
    int mark_errors = 0;
    int mark_blocks = 0;
    int n_inst16 = 0;
    int n_inst32 = 0;
    int n_cross = 0;
    int n_fault = 0;
    int n_taken = 0;
    int cycles = 0;

    `include "fetch_ref.svh"

    fetch_top dut (
        .clk                ( clk                ),
        .rst                ( rst                ),
        .i_squash_vld       ( i_squash_vld       ),
        .i_squash_pc        ( i_squash_pc        ),
        .i_br_update_vld    ( i_br_update_vld    ),
        .i_br_update_pc     ( i_br_update_pc     ),
        .i_br_update_target ( i_br_update_target ),
        .o_mem_req          ( o_mem_req          ),
        .o_mem_addr         ( o_mem_addr         ),
        .i_mem_rdata        ( i_mem_rdata        ),
        .i_fetch_rdy        ( i_fetch_rdy        ),
        .o_fetch_vld        ( o_fetch_vld        ),
        .o_fetch_slot       ( o_fetch_slot       )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [`MEM_DATA_BITS-1:0] read_line(input logic [`FETCH_XLEN-1:0] addr);
        logic [`MEM_DATA_BITS-1:0] data;
        for (int k = 0; k < 8; k++) begin
            data[16*k +: 16] = read_hw(addr + 32'(2 * k));
        end
        return data;
    endfunction

    // memory answers a request exactly one cycle later
    always @(negedge clk) begin
        req_seen = (o_mem_req === 1'b1);
        req_addr = o_mem_addr;
    end

    always @(posedge clk) begin
        if (req_seen) begin
            i_mem_rdata <= read_line(req_addr);
        end
    end

    task automatic flag_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("error %s: got %h expected %h in block %h", sig, got, exp, ref_pc);
        errors++;
    endtask

    task automatic check_block();
        logic [`FETCH_SLOTS-1:0]                        exp_vld;
        fetch_inst_pkg::fetch_slot_t [`FETCH_SLOTS-1:0] exp_slot;
        expected_slots(ref_pc, exp_vld, exp_slot);
        if (o_fetch_vld !== exp_vld) begin
            flag_mismatch("o_fetch_vld", 32'(o_fetch_vld), 32'(exp_vld));
        end
        for (int l = 0; l < `FETCH_SLOTS; l++) begin
            if (exp_vld[l]) begin
                if (o_fetch_slot[l].pc !== exp_slot[l].pc) begin
                    flag_mismatch($sformatf("o_fetch_slot[%0d].pc", l),
                                  o_fetch_slot[l].pc, exp_slot[l].pc);
                end
                if (o_fetch_slot[l].inst !== exp_slot[l].inst) begin
                    flag_mismatch($sformatf("o_fetch_slot[%0d].inst", l),
                                  o_fetch_slot[l].inst, exp_slot[l].inst);
                end
                if (o_fetch_slot[l].fault !== exp_slot[l].fault) begin
                    flag_mismatch($sformatf("o_fetch_slot[%0d].fault", l),
                                  32'(o_fetch_slot[l].fault), 32'(exp_slot[l].fault));
                end
                if (exp_slot[l].fault == fetch_inst_pkg::FAULT_MISALIGNED) begin
                    if (o_fetch_slot[l].fault === fetch_inst_pkg::FAULT_MISALIGNED) begin
                        n_fault++;
                    end
                end else if (o_fetch_slot[l].kind !== exp_slot[l].kind) begin
                    flag_mismatch($sformatf("o_fetch_slot[%0d].kind", l),
                                  32'(o_fetch_slot[l].kind), 32'(exp_slot[l].kind));
                end else if (exp_slot[l].kind == fetch_inst_pkg::INST32) begin
                    n_inst32++;
                    if (exp_slot[l].pc[2:1] == 2'b11) begin
                        n_cross++;
                    end
                end else begin
                    n_inst16++;
                end
            end
        end
        blocks_checked++;
        // the block after a table hit opens at the branch target
        if (hit_pending && o_fetch_vld[0] === 1'b1 && o_fetch_slot[0].pc === ref_pc) begin
            n_taken++;
        end
        hit_pending = table_hit(ref_pc);
        ref_pc = next_block(ref_pc);
    endtask

    // squash and table writes take effect at the next edge
    always @(negedge clk) begin
        if (rst) begin
            ref_pc      = `FETCH_RESET_PC;
            hit_pending = 1'b0;
            for (int e = 0; e < `BTB_ENTRIES; e++) begin
                ref_btb_vld[e] = 1'b0;
            end
        end else begin
            if (o_fetch_vld !== '0) begin
                check_block();
            end
            if (i_squash_vld) begin
                ref_pc      = i_squash_pc;
                hit_pending = 1'b0;
            end
            if (i_br_update_vld) begin
                ref_btb_vld[i_br_update_pc[4:3]]    = 1'b1;
                ref_btb_tag[i_br_update_pc[4:3]]    = i_br_update_pc[`FETCH_XLEN-1:3];
                ref_btb_target[i_br_update_pc[4:3]] = i_br_update_target;
            end
        end
    end

    task automatic fill_memory();
        logic [15:0] hw;
        for (int i = 0; i < MEM_HWORDS; i++) begin
            hw = 16'($urandom);
            // half of the halfwords open a 32-bit instruction
            if ($urandom % 2 == 0) begin
                hw[1:0] = 2'b11;
            end else begin
                hw[1:0] = 2'($urandom % 3);
            end
            mem_hw[i] = hw;
        end
    endtask

    task automatic put_hw(input logic [`FETCH_XLEN-1:0] addr, input logic [15:0] value);
        mem_hw[addr[12:1]] = value;
    endtask

    task automatic wait_blocks(input int n);
        int target;
        target = blocks_checked + n;
        while (blocks_checked < target) begin
            @(posedge clk);
        end
    endtask

    task automatic squash_to(input logic [31:0] pc, input logic upd,
                             input logic [31:0] upd_pc, input logic [31:0] upd_target);
        @(posedge clk);
        i_squash_vld       <= 1'b1;
        i_squash_pc        <= pc;
        i_br_update_vld    <= upd;
        i_br_update_pc     <= upd_pc;
        i_br_update_target <= upd_target;
        @(posedge clk);
        i_squash_vld    <= 1'b0;
        i_br_update_vld <= 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d blocks, %0d errors", num, name,
                 blocks_checked - mark_blocks, errors - mark_errors);
        mark_blocks = blocks_checked;
        mark_errors = errors;
    endtask

    // fails the run if the cycle budget runs out
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int snap16;
        int snap32;
        int snap_cross;
        int snap_fault;
        int snap_taken;
        int target;
        int low_left;
        int low_cycles;
        void'($urandom(54800));
        fill_memory();
        rst                = 1'b1;
        i_squash_vld       = 1'b0;
        i_squash_pc        = '0;
        i_br_update_vld    = 1'b0;
        i_br_update_pc     = '0;
        i_br_update_target = '0;
        i_mem_rdata        = '0;
        i_fetch_rdy        = 1'b1;

        repeat (9) @(posedge clk);
        @(negedge clk);
        if (o_mem_req !== 1'b0) begin
            flag_mismatch("o_mem_req", 32'(o_mem_req), 32'h0);
        end
        if (o_fetch_vld !== '0) begin
            flag_mismatch("o_fetch_vld", 32'(o_fetch_vld), 32'h0);
        end
        @(posedge clk);
        rst <= 1'b0;
        wait_blocks(40);
        end_test(1, "reset stream");

        // 16-bit, 32-bit, then a 32-bit that spills into the next word
        put_hw(32'h1800, 16'h4501);
        put_hw(32'h1802, 16'h8a13);
        put_hw(32'h1804, 16'h1234);
        put_hw(32'h1806, 16'h0fb7);
        put_hw(32'h1808, 16'h0593);
        put_hw(32'h180a, 16'h00c5);
        put_hw(32'h180c, 16'h4082);
        put_hw(32'h180e, 16'h8082);
        snap16     = n_inst16;
        snap32     = n_inst32;
        snap_cross = n_cross;
        squash_to(32'h1800, 1'b0, '0, '0);
        wait_blocks(30);
        if (n_cross == snap_cross || n_inst16 == snap16 || n_inst32 == snap32) begin
            $display("mixed widths: not every instruction form showed up in the slots");
            errors++;
        end
        end_test(2, "mixed widths");

        squash_to(32'h0a40, 1'b0, '0, '0);
        wait_blocks(30);
        end_test(3, "even squash");

        snap_fault = n_fault;
        squash_to(32'h1203, 1'b0, '0, '0);
        wait_blocks(10);
        if (n_fault != snap_fault + 1) begin
            $display("odd squash: expected one misaligned fault slot, saw %0d",
                     n_fault - snap_fault);
            errors++;
        end
        end_test(4, "odd squash");

        snap_taken = n_taken;
        squash_to(32'h0c00, 1'b1, 32'h0c14, 32'h0e06);
        wait_blocks(20);
        if (n_taken == snap_taken) begin
            $display("branch target: the stream never followed the installed branch");
            errors++;
        end
        end_test(5, "branch target");

        low_left   = 0;
        low_cycles = 0;
        target     = blocks_checked + 150;
        while (blocks_checked < target) begin
            @(posedge clk);
            if (low_left == 0 && $urandom % 6 == 0) begin
                // long stalls fill the queue and stop the predictor
                low_left = 1 + $urandom % 16;
            end
            if (low_left > 0) begin
                i_fetch_rdy <= 1'b0;
                low_left--;
                low_cycles++;
            end else begin
                i_fetch_rdy <= 1'b1;
            end
        end
        @(posedge clk);
        i_fetch_rdy <= 1'b1;
        if (low_cycles == 0) begin
            $display("random back-pressure: i_fetch_rdy was never held low");
            errors++;
        end
        end_test(6, "random back-pressure");

        $display("checked %0d blocks in %0d cycles, %0d errors", blocks_checked, cycles, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
+incdir+bench
logic/fetch_addr_pkg.sv
logic/fetch_inst_pkg.sv
logic/block_if.sv
logic/next_block_pred.sv
logic/fetch_target_queue.sv
logic/fetch_aligner.sv
logic/fetch_top.sv
bench/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - logic
    files:
      - logic/fetch_addr_pkg.sv
      - logic/fetch_inst_pkg.sv
      - logic/block_if.sv
      - logic/next_block_pred.sv
      - logic/fetch_target_queue.sv
      - logic/fetch_aligner.sv
      - logic/fetch_top.sv
  - target: simulation
    include_dirs:
      - logic
      - bench
    files:
      - bench/tb_fetch_top.sv
